// ==== hdl/ascon_defines.svh ====
`ifndef ASCON_DEFINES_SVH
`define ASCON_DEFINES_SVH

//////////////////////////////////////////////////
// State geometry
//////////////////////////////////////////////////

// Width of one state lane in bits
`define ASCON_LANE_W 64

// Lanes x0 to x4
`define ASCON_LANES 5

//////////////////////////////////////////////////
// Permutation schedule
//////////////////////////////////////////////////

// Rounds of initialization and finalization
`define ASCON_PA_ROUNDS 12

// Rounds after associated data and after plaintext
`define ASCON_PB_ROUNDS 8

// Ascon-128a initialization vector, loaded into x0
`define ASCON_IV 64'h80800c0800000000

`endif

// ==== hdl/ascon_pkg.sv ====
`include "ascon_defines.svh"

package ascon_pkg;

    //////////////////////////////////////////////////
    // Vector types
    //////////////////////////////////////////////////

    // One state lane
    typedef logic [`ASCON_LANE_W-1:0] lane_t;

    // Key, nonce, data, ciphertext or tag, two lanes wide
    typedef logic [2*`ASCON_LANE_W-1:0] block_t;

    // One bit column across all lanes, bit i taken from lane xi
    typedef logic [`ASCON_LANES-1:0] slice_t;

    // Round index within a 12-round schedule
    typedef logic [3:0] round_idx_t;

    //////////////////////////////////////////////////
    // Sequencer phases
    //////////////////////////////////////////////////

    typedef enum logic [2:0]
    {
        IDLE,
        INIT,
        ASSOC,
        TEXT,
        FINAL
    } phase_t;

endpackage

// ==== hdl/ascon_sbox_column.sv ====
`timescale 1ns/1ps

module ascon_sbox_column
(
    input  ascon_pkg::slice_t col_in,
    output ascon_pkg::slice_t col_out
);

    ascon_pkg::slice_t mix;
    ascon_pkg::slice_t chi;

    // Input xor mix
    assign mix[0] = col_in[0] ^ col_in[4];
    assign mix[1] = col_in[1];
    assign mix[2] = col_in[1] ^ col_in[2];
    assign mix[3] = col_in[3];
    assign mix[4] = col_in[3] ^ col_in[4];

    // Nonlinear step, each bit against its two upper neighbours
    always_comb
    begin
        for (int i = 0; i < 5; i++)
        begin
            chi[i] = mix[i] ^ (~mix[(i + 1) % 5] & mix[(i + 2) % 5]);
        end
    end

    // Output xor mix
    assign col_out[0] = chi[0] ^ chi[4];
    assign col_out[1] = chi[1] ^ chi[0];
    assign col_out[2] = ~chi[2];
    assign col_out[3] = chi[3] ^ chi[2];
    assign col_out[4] = chi[4];

endmodule

// ==== hdl/ascon_linear_layer.sv ====
`timescale 1ns/1ps

module ascon_linear_layer
(
    input  ascon_pkg::lane_t s0,
    input  ascon_pkg::lane_t s1,
    input  ascon_pkg::lane_t s2,
    input  ascon_pkg::lane_t s3,
    input  ascon_pkg::lane_t s4,
    output ascon_pkg::lane_t x0,
    output ascon_pkg::lane_t x1,
    output ascon_pkg::lane_t x2,
    output ascon_pkg::lane_t x3,
    output ascon_pkg::lane_t x4
);

    // Right rotation of one lane
    function automatic ascon_pkg::lane_t rotr
    (
        input ascon_pkg::lane_t v,
        input int               n
    );
        return (v >> n) | (v << ($bits(v) - n));
    endfunction

    // Lane xored with two rotations of itself
    function automatic ascon_pkg::lane_t diffuse
    (
        input ascon_pkg::lane_t v,
        input int               a,
        input int               b
    );
        return v ^ rotr(v, a) ^ rotr(v, b);
    endfunction

    //////////////////////////////////////////////////
    // Per-lane diffusion
    //////////////////////////////////////////////////

    assign x0 = diffuse(s0, 19, 28);
    assign x1 = diffuse(s1, 61, 39);
    assign x2 = diffuse(s2, 1, 6);
    assign x3 = diffuse(s3, 10, 17);
    assign x4 = diffuse(s4, 7, 41);

endmodule

// ==== hdl/ascon_sequencer.sv ====
`timescale 1ns/1ps
`include "ascon_defines.svh"

module ascon_sequencer
(
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  ascon_pkg::block_t   key,
    input  ascon_pkg::block_t   nonce,
    input  ascon_pkg::block_t   ad,
    input  ascon_pkg::block_t   pt,
    input  ascon_pkg::lane_t    lin_x0,
    input  ascon_pkg::lane_t    lin_x1,
    input  ascon_pkg::lane_t    lin_x2,
    input  ascon_pkg::lane_t    lin_x3,
    input  ascon_pkg::lane_t    lin_x4,
    output ascon_pkg::lane_t    sbox_x0,
    output ascon_pkg::lane_t    sbox_x1,
    output ascon_pkg::lane_t    sbox_x2,
    output ascon_pkg::lane_t    sbox_x3,
    output ascon_pkg::lane_t    sbox_x4,
    output ascon_pkg::block_t   c,
    output ascon_pkg::block_t   t,
    output logic                busy,
    output logic                done
);

    // Every phase ends on round 11; 8-round phases start at round 4
    localparam ascon_pkg::round_idx_t LAST_ROUND =
        ascon_pkg::round_idx_t'(`ASCON_PA_ROUNDS - 1);
    localparam ascon_pkg::round_idx_t PB_FIRST =
        ascon_pkg::round_idx_t'(`ASCON_PA_ROUNDS - `ASCON_PB_ROUNDS);

    ascon_pkg::phase_t     phase;
    ascon_pkg::round_idx_t round;

    ascon_pkg::lane_t  st  [0:`ASCON_LANES-1];
    ascon_pkg::lane_t  rnd [0:`ASCON_LANES-1];
    ascon_pkg::lane_t  nxt [0:`ASCON_LANES-1];

    ascon_pkg::block_t key_q;
    ascon_pkg::block_t ad_q;
    ascon_pkg::block_t pt_q;
    ascon_pkg::block_t ct_q;

    ascon_pkg::lane_t  khi;
    ascon_pkg::lane_t  klo;
    ascon_pkg::lane_t  ahi;
    ascon_pkg::lane_t  alo;
    ascon_pkg::lane_t  phi;
    ascon_pkg::lane_t  plo;

    logic [7:0]        rc;
    logic              accept;
    logic              last_round;

    assign accept     = start && (phase == ascon_pkg::IDLE);
    assign last_round = (round == LAST_ROUND);
    assign busy       = (phase != ascon_pkg::IDLE);

    assign {khi, klo} = key_q;
    assign {ahi, alo} = ad_q;
    assign {phi, plo} = pt_q;

    //////////////////////////////////////////////////
    // Round constant into the S-box feed
    //////////////////////////////////////////////////

    // High nibble counts down as the low nibble counts up
    assign rc = {4'hf - round, round};

    assign sbox_x0 = st[0];
    assign sbox_x1 = st[1];
    assign sbox_x2 = st[2] ^ {{(`ASCON_LANE_W-8){1'b0}}, rc};
    assign sbox_x3 = st[3];
    assign sbox_x4 = st[4];

    //////////////////////////////////////////////////
    // Round result and phase-boundary injections
    //////////////////////////////////////////////////

    assign rnd[0] = lin_x0;
    assign rnd[1] = lin_x1;
    assign rnd[2] = lin_x2;
    assign rnd[3] = lin_x3;
    assign rnd[4] = lin_x4;

    always_comb
    begin
        nxt = rnd;
        if (last_round)
        begin
            case (phase)
                ascon_pkg::INIT:
                begin
                    // Key mix, then absorb the associated data block
                    nxt[3] = rnd[3] ^ khi;
                    nxt[4] = rnd[4] ^ klo;
                    nxt[0] = rnd[0] ^ ahi;
                    nxt[1] = rnd[1] ^ alo;
                end
                ascon_pkg::ASSOC:
                begin
                    // Domain separation, then plaintext in the rate
                    nxt[4] = rnd[4] ^ `ASCON_LANE_W'(1);
                    nxt[0] = rnd[0] ^ phi;
                    nxt[1] = rnd[1] ^ plo;
                end
                ascon_pkg::TEXT:
                begin
                    nxt[2] = rnd[2] ^ khi;
                    nxt[3] = rnd[3] ^ klo;
                end
                default:
                begin
                    nxt = rnd;
                end
            endcase
        end
    end

    // State lanes and latched blocks
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            key_q       <= key;
            ad_q        <= ad;
            pt_q        <= pt;
            st[0]       <= `ASCON_IV;
            {st[1], st[2]} <= key;
            {st[3], st[4]} <= nonce;
        end
        else if (busy)
        begin
            st <= nxt;
            if ((phase == ascon_pkg::ASSOC) && last_round)
            begin
                ct_q <= {nxt[0], nxt[1]};
            end
        end
    end

    //////////////////////////////////////////////////
    // Phase machine and results
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            phase <= ascon_pkg::IDLE;
            round <= '0;
            done  <= 1'b0;
            c     <= '0;
            t     <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (busy && !last_round)
            begin
                round <= round + 1'b1;
            end
            case (phase)
                ascon_pkg::IDLE:
                begin
                    if (start)
                    begin
                        phase <= ascon_pkg::INIT;
                        round <= '0;
                    end
                end
                ascon_pkg::INIT:
                begin
                    if (last_round)
                    begin
                        phase <= ascon_pkg::ASSOC;
                        round <= PB_FIRST;
                    end
                end
                ascon_pkg::ASSOC:
                begin
                    if (last_round)
                    begin
                        phase <= ascon_pkg::TEXT;
                        round <= PB_FIRST;
                    end
                end
                ascon_pkg::TEXT:
                begin
                    if (last_round)
                    begin
                        phase <= ascon_pkg::FINAL;
                        round <= '0;
                    end
                end
                ascon_pkg::FINAL:
                begin
                    if (last_round)
                    begin
                        phase <= ascon_pkg::IDLE;
                        round <= '0;
                        done  <= 1'b1;
                        c     <= ct_q;
                        t     <= {rnd[3], rnd[4]} ^ key_q;
                    end
                end
                default:
                begin
                    phase <= ascon_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

// ==== hdl/ascon_encrypt_1block.sv ====
`timescale 1ns/1ps
`include "ascon_defines.svh"

module ascon_encrypt_1block
(
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  ascon_pkg::block_t key,
    input  ascon_pkg::block_t nonce,
    input  ascon_pkg::block_t ad,
    input  ascon_pkg::block_t pt,
    output ascon_pkg::block_t c,
    output ascon_pkg::block_t t,
    output logic              busy,
    output logic              done
);

    wire ascon_pkg::lane_t sbox_x0, sbox_x1, sbox_x2, sbox_x3, sbox_x4;
    wire ascon_pkg::lane_t sub_x0, sub_x1, sub_x2, sub_x3, sub_x4;
    wire ascon_pkg::lane_t lin_x0, lin_x1, lin_x2, lin_x3, lin_x4;

    ascon_sequencer u_sequencer
    (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .key     (key),
        .nonce   (nonce),
        .ad      (ad),
        .pt      (pt),
        .lin_x0  (lin_x0),
        .lin_x1  (lin_x1),
        .lin_x2  (lin_x2),
        .lin_x3  (lin_x3),
        .lin_x4  (lin_x4),
        .sbox_x0 (sbox_x0),
        .sbox_x1 (sbox_x1),
        .sbox_x2 (sbox_x2),
        .sbox_x3 (sbox_x3),
        .sbox_x4 (sbox_x4),
        .c       (c),
        .t       (t),
        .busy    (busy),
        .done    (done)
    );

    //////////////////////////////////////////////////
    // Substitution layer, one S-box per bit column
    //////////////////////////////////////////////////

    for (genvar b = 0; b < `ASCON_LANE_W; b++)
    begin : g_col
        wire ascon_pkg::slice_t col_in;
        wire ascon_pkg::slice_t col_out;

        // Bit i of the column comes from lane xi
        assign col_in = {sbox_x4[b], sbox_x3[b], sbox_x2[b], sbox_x1[b], sbox_x0[b]};

        ascon_sbox_column u_sbox
        (
            .col_in  (col_in),
            .col_out (col_out)
        );

        assign sub_x0[b] = col_out[0];
        assign sub_x1[b] = col_out[1];
        assign sub_x2[b] = col_out[2];
        assign sub_x3[b] = col_out[3];
        assign sub_x4[b] = col_out[4];
    end

    ascon_linear_layer u_linear
    (
        .s0 (sub_x0),
        .s1 (sub_x1),
        .s2 (sub_x2),
        .s3 (sub_x3),
        .s4 (sub_x4),
        .x0 (lin_x0),
        .x1 (lin_x1),
        .x2 (lin_x2),
        .x3 (lin_x3),
        .x4 (lin_x4)
    );

endmodule

// ==== sim/ascon_encrypt_1block_checker.sv ====
`timescale 1ns/1ps

module ascon_encrypt_1block_checker
(
    input logic clk,
    input logic reset,
    input logic start,
    input logic busy,
    input logic done
);

    // Done is a single-cycle pulse
    assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
    else $error("done stayed high for more than one cycle");

    // Busy drops on the same edge that raises done
    assert property (@(posedge clk) disable iff (reset)
        $rose(done) |-> $fell(busy))
    else $error("busy did not fall together with done");

    // Accepted start leads to done 40 cycles later, not earlier
    assert property (@(posedge clk) disable iff (reset)
        (start && !busy) |=> (!done) [*40] ##1 done)
    else $error("done did not follow the accepted start by 40 cycles");

endmodule

bind ascon_encrypt_1block ascon_encrypt_1block_checker u_checker
(
    .clk   (clk),
    .reset (reset),
    .start (start),
    .busy  (busy),
    .done  (done)
);

// ==== sim/tb_ascon_encrypt_1block.sv ====
`timescale 1ns/1ps
`include "ascon_defines.svh"

module tb_ascon_encrypt_1block;

    localparam int NUM_BLOCKS = 50;
    localparam int LATENCY    = 40;
    localparam int WAIT_LIMIT = 100;

    logic              clk;
    logic              reset;
    logic              start;
    ascon_pkg::block_t key;
    ascon_pkg::block_t nonce;
    ascon_pkg::block_t ad;
    ascon_pkg::block_t pt;
    ascon_pkg::block_t c;
    ascon_pkg::block_t t;
    logic              busy;
    logic              done;

    logic [63:0]       rng_state;
    logic [63:0]       ms [0:4];
    ascon_pkg::block_t cur_key;
    ascon_pkg::block_t cur_nonce;
    ascon_pkg::block_t cur_ad;
    ascon_pkg::block_t cur_pt;
    ascon_pkg::block_t exp_c;
    ascon_pkg::block_t exp_t;
    bit                chained;
    int                cycles;

    ascon_encrypt_1block uut
    (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .key   (key),
        .nonce (nonce),
        .ad    (ad),
        .pt    (pt),
        .c     (c),
        .t     (t),
        .busy  (busy),
        .done  (done)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    //////////////////////////////////////////////////
    // Stimulus source
    //////////////////////////////////////////////////

    function automatic logic [63:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 7;
        rng_state ^= rng_state << 17;
        return rng_state;
    endfunction

    function automatic logic [127:0] random_block();
        logic [63:0] hi;
        logic [63:0] lo;
        hi = next_random();
        lo = next_random();
        return {hi, lo};
    endfunction

    //////////////////////////////////////////////////
    // Reference model of the permutation and mode
    //////////////////////////////////////////////////

    function automatic logic [63:0] ror64(input logic [63:0] v, input int n);
        return (v >> n) | (v << (64 - n));
    endfunction

    task automatic model_round(input int j);
        logic [63:0] x0, x1, x2, x3, x4;
        logic [63:0] t0, t1, t2, t3, t4;
        logic [7:0]  rc;
        rc = 8'(((15 - j) << 4) | j);
        x0 = ms[0];
        x1 = ms[1];
        x2 = ms[2] ^ {56'd0, rc};
        x3 = ms[3];
        x4 = ms[4];
        // Substitution in lane-parallel form
        x0 ^= x4;
        x4 ^= x3;
        x2 ^= x1;
        t0 = ~x0 & x1;
        t1 = ~x1 & x2;
        t2 = ~x2 & x3;
        t3 = ~x3 & x4;
        t4 = ~x4 & x0;
        x0 ^= t1;
        x1 ^= t2;
        x2 ^= t3;
        x3 ^= t4;
        x4 ^= t0;
        x1 ^= x0;
        x0 ^= x4;
        x3 ^= x2;
        x2 = ~x2;
        // Linear diffusion
        ms[0] = x0 ^ ror64(x0, 19) ^ ror64(x0, 28);
        ms[1] = x1 ^ ror64(x1, 61) ^ ror64(x1, 39);
        ms[2] = x2 ^ ror64(x2, 1) ^ ror64(x2, 6);
        ms[3] = x3 ^ ror64(x3, 10) ^ ror64(x3, 17);
        ms[4] = x4 ^ ror64(x4, 7) ^ ror64(x4, 41);
    endtask

    // Rounds run from first_round up to 11
    task automatic model_permute(input int first_round);
        for (int j = first_round; j < 12; j++)
        begin
            model_round(j);
        end
    endtask

    task automatic model_encrypt
    (
        input  logic [127:0] k,
        input  logic [127:0] n,
        input  logic [127:0] a,
        input  logic [127:0] p,
        output logic [127:0] c_exp,
        output logic [127:0] t_exp
    );
        ms[0] = `ASCON_IV;
        {ms[1], ms[2]} = k;
        {ms[3], ms[4]} = n;
        model_permute(0);
        ms[3] ^= k[127:64];
        ms[4] ^= k[63:0];
        ms[0] ^= a[127:64];
        ms[1] ^= a[63:0];
        model_permute(4);
        ms[4] ^= 64'd1;
        ms[0] ^= p[127:64];
        ms[1] ^= p[63:0];
        c_exp = {ms[0], ms[1]};
        model_permute(4);
        ms[2] ^= k[127:64];
        ms[3] ^= k[63:0];
        model_permute(0);
        t_exp = {ms[3], ms[4]} ^ k;
    endtask

    //////////////////////////////////////////////////
    // Checks and waits
    //////////////////////////////////////////////////

    task automatic fail_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value
    (
        input logic [127:0] actual,
        input logic [127:0] expected,
        input string        what
    );
        if (actual !== expected)
        begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            fail_run();
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy)
        begin
            if (n >= WAIT_LIMIT)
            begin
                $display("Timeout: busy stayed high while waiting to start a block");
                fail_run();
            end
            @(negedge clk);
            n++;
        end
    endtask

    // Counts cycles to done
    // Noisy mode toggles start and the inputs meanwhile
    task automatic wait_done(input bit noisy);
        logic [63:0] r;
        cycles = 0;
        while (!done)
        begin
            if (cycles >= WAIT_LIMIT)
            begin
                $display("Timeout: done did not arrive after an accepted start");
                fail_run();
            end
            if (noisy)
            begin
                r = next_random();
                start = r[0];
                key   = random_block();
                nonce = random_block();
                ad    = random_block();
                pt    = random_block();
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic pick_vector();
        cur_key   = random_block();
        cur_nonce = random_block();
        cur_ad    = random_block();
        cur_pt    = random_block();
    endtask

    task automatic drive_vector();
        key   = cur_key;
        nonce = cur_nonce;
        ad    = cur_ad;
        pt    = cur_pt;
        start = 1'b1;
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial
    begin
        rng_state = 64'd78824;
        reset     = 1'b1;
        start     = 1'b0;
        key       = '0;
        nonce     = '0;
        ad        = '0;
        pt        = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value(busy, 1'b0, "busy after reset");
        check_value(done, 1'b0, "done after reset");
        check_value(c, '0, "c after reset");
        check_value(t, '0, "t after reset");

        pick_vector();
        chained = 1'b0;
        for (int i = 0; i < NUM_BLOCKS; i++)
        begin
            model_encrypt(cur_key, cur_nonce, cur_ad, cur_pt, exp_c, exp_t);
            if (!chained)
            begin
                wait_idle();
                drive_vector();
            end
            @(negedge clk);
            start = 1'b0;
            check_value(busy, 1'b1, "busy after start");
            wait_done(i % 2 == 1);
            check_value(cycles, LATENCY, "cycles from start to done");
            check_value(c, exp_c, "ciphertext");
            check_value(t, exp_t, "tag");
            check_value(busy, 1'b0, "busy at done");
            // Every fourth block is followed by a start on the done cycle
            chained = (i % 4 == 3) && (i < NUM_BLOCKS - 1);
            pick_vector();
            if (chained)
            begin
                drive_vector();
            end
            else
            begin
                start = 1'b0;
                @(negedge clk);
            end
        end

        $display("All checks passed");
        $finish;
    end

endmodule

// ==== ascon_encrypt_1block.f ====
+incdir+hdl
hdl/ascon_pkg.sv
hdl/ascon_sbox_column.sv
hdl/ascon_linear_layer.sv
hdl/ascon_sequencer.sv
hdl/ascon_encrypt_1block.sv
sim/ascon_encrypt_1block_checker.sv
sim/tb_ascon_encrypt_1block.sv
